//--- hdl/db_pkg.sv
`default_nettype none

package db_pkg;

    // ====================
    // Sizes
    // ====================
    localparam int db_size   = 256;
    localparam int key_wid   = $clog2(db_size);
    localparam int value_wid = 32;

    // Update queue geometry
    localparam int upd_depth   = 4;
    localparam int upd_ptr_wid = $clog2(upd_depth);
    localparam int upd_cnt_wid = $clog2(upd_depth + 1);

    // ====================
    // Types
    // ====================
    typedef logic [key_wid-1:0]   key_t;
    typedef logic [value_wid-1:0] value_t;

    // Control port commands
    typedef enum logic [2:0] {
        CMD_GET     = 3'd0,
        CMD_SET     = 3'd1,
        CMD_UNSET   = 3'd2,
        CMD_REPLACE = 3'd3,
        CMD_CLEAR   = 3'd4
    } db_cmd_t;

    // Controller states
    typedef enum logic [2:0] {
        ST_INIT  = 3'd0,
        ST_IDLE  = 3'd1,
        ST_READ  = 3'd2,
        ST_RESP  = 3'd3,
        ST_SWEEP = 3'd4
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/db_store_array.sv
`default_nettype none
`timescale 1ns/1ps

module db_store_array (
    input  logic            clk,
    input  logic            arst_n,
    // Port A, read/write
    input  db_pkg::key_t    a_addr,
    input  logic            a_wr,
    input  logic            a_wvalid,
    input  db_pkg::value_t  a_wvalue,
    output logic            a_rvalid,
    output db_pkg::value_t  a_rvalue,
    // Port B, read only
    input  db_pkg::key_t    b_addr,
    output logic            b_rvalid,
    output db_pkg::value_t  b_rvalue,
    // Clear sweep
    input  logic            sweep_start,
    output logic            sweep_busy
);
    import db_pkg::*;

    value_t             value_mem [db_size];
    logic [db_size-1:0] valid_mem;
    key_t               sweep_cnt;

    // ====================
    // Sweep counter
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sweep_busy <= 1'b0;
            sweep_cnt  <= '0;
        end else if (sweep_start) begin
            sweep_busy <= 1'b1;
            sweep_cnt  <= '0;
        end else if (sweep_busy) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            // Last entry cleared on this edge
            if (sweep_cnt == key_t'(db_size - 1)) begin
                sweep_busy <= 1'b0;
            end
        end
    end

    // ====================
    // Memory
    // ====================
    always_ff @(posedge clk) begin
        if (sweep_busy) begin
            value_mem[sweep_cnt] <= '0;
            valid_mem[sweep_cnt] <= 1'b0;
        end else if (a_wr) begin
            value_mem[a_addr] <= a_wvalue;
            valid_mem[a_addr] <= a_wvalid;
        end
    end

    // Synchronous reads, old contents on a same-address write
    always_ff @(posedge clk) begin
        a_rvalue <= value_mem[a_addr];
        a_rvalid <= valid_mem[a_addr];
        b_rvalue <= value_mem[b_addr];
        b_rvalid <= valid_mem[b_addr];
    end

    // Controller must hold port A writes off until the sweep ends
    a_no_wr_in_sweep : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(a_wr && sweep_busy)
    );

endmodule

`default_nettype wire

//--- hdl/db_update_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module db_update_fifo (
    input  logic            clk,
    input  logic            arst_n,
    // Write side
    input  logic            push,
    input  db_pkg::key_t    push_key,
    input  logic            push_valid,
    input  db_pkg::value_t  push_value,
    // Read side
    input  logic            pop,
    output db_pkg::key_t    head_key,
    output logic            head_valid,
    output db_pkg::value_t  head_value,
    output logic            not_empty,
    // Levels
    output logic            full,
    output logic            busy
);
    import db_pkg::*;

    key_t                   key_mem   [upd_depth];
    logic [upd_depth-1:0]   valid_mem;
    value_t                 value_mem [upd_depth];
    logic [upd_ptr_wid-1:0] wr_ptr;
    logic [upd_ptr_wid-1:0] rd_ptr;
    logic [upd_cnt_wid-1:0] count;

    // ====================
    // Pointers and count
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            key_mem[wr_ptr]   <= push_key;
            valid_mem[wr_ptr] <= push_valid;
            value_mem[wr_ptr] <= push_value;
        end
    end

    assign head_key   = key_mem[rd_ptr];
    assign head_valid = valid_mem[rd_ptr];
    assign head_value = value_mem[rd_ptr];

    assign not_empty = (count != '0);
    assign full      = (count == upd_cnt_wid'(upd_depth));
    assign busy      = not_empty || pop;

    a_no_push_full : assert property (
        @(posedge clk) disable iff (!arst_n) push |-> !full
    );

    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!arst_n) pop |-> not_empty
    );

endmodule

`default_nettype wire

//--- hdl/db_query_pipe.sv
`default_nettype none
`timescale 1ns/1ps

module db_query_pipe (
    input  logic            clk,
    input  logic            arst_n,
    // Application query
    input  logic            qry_req,
    input  db_pkg::key_t    qry_key,
    output logic            qry_done,
    output logic            qry_valid,
    output db_pkg::value_t  qry_value,
    // Store port B
    output db_pkg::key_t    b_addr,
    input  logic            b_rvalid,
    input  db_pkg::value_t  b_rvalue,
    // Port A write snoop
    input  logic            a_wr,
    input  db_pkg::key_t    a_addr,
    input  logic            a_wvalid,
    input  db_pkg::value_t  a_wvalue
);
    import db_pkg::*;

    logic   s1_req;
    logic   s1_hit;
    logic   s1_wvalid;
    value_t s1_wvalue;

    // ====================
    // Stage 1
    // ====================
    assign b_addr = qry_key;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_req <= 1'b0;
            s1_hit <= 1'b0;
        end else begin
            s1_req <= qry_req;
            // Write lands on the same edge as the array read
            s1_hit <= qry_req && a_wr && (a_addr == qry_key);
        end
    end

    always_ff @(posedge clk) begin
        s1_wvalid <= a_wvalid;
        s1_wvalue <= a_wvalue;
    end

    // ====================
    // Stage 2
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            qry_done <= 1'b0;
        end else begin
            qry_done <= s1_req;
        end
    end

    always_ff @(posedge clk) begin
        qry_valid <= s1_hit ? s1_wvalid : b_rvalid;
        qry_value <= s1_hit ? s1_wvalue : b_rvalue;
    end

endmodule

`default_nettype wire

//--- hdl/db_ctrl_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module db_ctrl_fsm (
    input  logic             clk,
    input  logic             arst_n,
    // Control port
    input  logic             ctrl_req,
    input  db_pkg::db_cmd_t  ctrl_cmd,
    input  db_pkg::key_t     ctrl_key,
    input  db_pkg::value_t   ctrl_value,
    output logic             ctrl_ready,
    output logic             ctrl_done,
    output logic             ctrl_rsp_valid,
    output db_pkg::value_t   ctrl_rsp_value,
    output logic             init_done,
    // Store port A
    output db_pkg::key_t     a_addr,
    output logic             a_wr,
    output logic             a_wvalid,
    output db_pkg::value_t   a_wvalue,
    input  logic             a_rvalid,
    input  db_pkg::value_t   a_rvalue,
    // Update queue head
    input  db_pkg::key_t     head_key,
    input  logic             head_valid,
    input  db_pkg::value_t   head_value,
    input  logic             not_empty,
    output logic             pop,
    // Clear sweep
    output logic             sweep_start,
    input  logic             sweep_busy
);
    import db_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    db_cmd_t     cmd_q;
    key_t        key_q;
    value_t      value_q;
    logic        accept;
    logic        drain;
    logic        sweep_end;

    // Control port wins over the update queue
    assign accept    = (state == ST_IDLE) && ctrl_req;
    assign drain     = (state == ST_IDLE) && !ctrl_req && not_empty;
    assign sweep_end = (state == ST_SWEEP) && !sweep_busy;

    // ====================
    // State machine
    // ====================
    always_comb begin
        state_nxt = state;
        case (state)
            ST_INIT: begin
                state_nxt = ST_SWEEP;
            end
            ST_IDLE: begin
                if (ctrl_req) begin
                    state_nxt = (ctrl_cmd == CMD_CLEAR) ? ST_SWEEP : ST_READ;
                end
            end
            ST_READ: begin
                state_nxt = ST_RESP;
            end
            ST_RESP: begin
                state_nxt = ST_IDLE;
            end
            ST_SWEEP: begin
                if (!sweep_busy) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_INIT;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_INIT;
            cmd_q     <= CMD_GET;
            init_done <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                cmd_q <= ctrl_cmd;
            end
            if (sweep_end) begin
                init_done <= 1'b1;
            end
        end
    end

    // Command operands
    always_ff @(posedge clk) begin
        if (accept) begin
            key_q   <= ctrl_key;
            value_q <= ctrl_value;
        end
    end

    // ====================
    // Port A source select
    // ====================
    always_comb begin
        a_addr   = key_q;
        a_wr     = 1'b0;
        a_wvalid = 1'b0;
        a_wvalue = '0;
        if (drain) begin
            a_addr   = head_key;
            a_wr     = 1'b1;
            a_wvalid = head_valid;
            a_wvalue = head_value;
        end else if (state == ST_RESP) begin
            case (cmd_q)
                CMD_SET, CMD_REPLACE: begin
                    a_wr     = 1'b1;
                    a_wvalid = 1'b1;
                    a_wvalue = value_q;
                end
                // Entry back to invalid and zero
                CMD_UNSET: begin
                    a_wr = 1'b1;
                end
                default: begin
                    a_wr = 1'b0;
                end
            endcase
        end
    end

    assign pop         = drain;
    assign sweep_start = (state == ST_INIT) || (accept && (ctrl_cmd == CMD_CLEAR));

    // Responses are zero after a clear
    assign ctrl_ready     = (state == ST_IDLE);
    assign ctrl_done      = (state == ST_RESP) || (sweep_end && init_done);
    assign ctrl_rsp_valid = (state == ST_RESP) && a_rvalid;
    assign ctrl_rsp_value = (state == ST_RESP) ? a_rvalue : '0;

    a_req_when_ready : assert property (
        @(posedge clk) disable iff (!arst_n) ctrl_req |-> ctrl_ready
    );

endmodule

`default_nettype wire

//--- hdl/db_core.sv
`default_nettype none
`timescale 1ns/1ps

module db_core (
    input  logic             clk,
    input  logic             arst_n,
    // Control port
    input  logic             ctrl_req,
    input  db_pkg::db_cmd_t  ctrl_cmd,
    input  db_pkg::key_t     ctrl_key,
    input  db_pkg::value_t   ctrl_value,
    output logic             ctrl_ready,
    output logic             ctrl_done,
    output logic             ctrl_rsp_valid,
    output db_pkg::value_t   ctrl_rsp_value,
    // Application updates
    input  logic             upd_req,
    input  db_pkg::key_t     upd_key,
    input  logic             upd_valid,
    input  db_pkg::value_t   upd_value,
    output logic             upd_full,
    output logic             upd_busy,
    // Application queries
    input  logic             qry_req,
    input  db_pkg::key_t     qry_key,
    output logic             qry_done,
    output logic             qry_valid,
    output db_pkg::value_t   qry_value,
    output logic             init_done
);
    import db_pkg::*;

    // Store port A
    key_t   a_addr;
    logic   a_wr;
    logic   a_wvalid;
    value_t a_wvalue;
    logic   a_rvalid;
    value_t a_rvalue;

    // Store port B
    key_t   b_addr;
    logic   b_rvalid;
    value_t b_rvalue;

    // Queue head and sweep
    key_t   head_key;
    logic   head_valid;
    value_t head_value;
    logic   not_empty;
    logic   pop;
    logic   sweep_start;
    logic   sweep_busy;

    db_ctrl_fsm u_ctrl (
        .clk, .arst_n,
        .ctrl_req, .ctrl_cmd, .ctrl_key, .ctrl_value,
        .ctrl_ready, .ctrl_done, .ctrl_rsp_valid, .ctrl_rsp_value,
        .init_done,
        .a_addr, .a_wr, .a_wvalid, .a_wvalue, .a_rvalid, .a_rvalue,
        .head_key, .head_valid, .head_value, .not_empty, .pop,
        .sweep_start, .sweep_busy
    );

    db_store_array u_store (
        .clk, .arst_n,
        .a_addr, .a_wr, .a_wvalid, .a_wvalue, .a_rvalid, .a_rvalue,
        .b_addr, .b_rvalid, .b_rvalue,
        .sweep_start, .sweep_busy
    );

    db_update_fifo u_fifo (
        .clk, .arst_n,
        .push       (upd_req),
        .push_key   (upd_key),
        .push_valid (upd_valid),
        .push_value (upd_value),
        .pop,
        .head_key, .head_valid, .head_value, .not_empty,
        .full       (upd_full),
        .busy       (upd_busy)
    );

    db_query_pipe u_qry (
        .clk, .arst_n,
        .qry_req, .qry_key, .qry_done, .qry_valid, .qry_value,
        .b_addr, .b_rvalid, .b_rvalue,
        .a_wr, .a_addr, .a_wvalid, .a_wvalue
    );

endmodule

`default_nettype wire

//--- bench/tb_db_core.sv
`default_nettype none
`timescale 1ns/1ps

module tb_db_core;
    import db_pkg::*;

    typedef struct packed {
        logic   valid;
        value_t value;
    } entry_t;

    localparam logic [31:0] seed        = 32'd53;
    localparam int          clk_half    = 10;
    localparam int          pool_size   = 8;
    localparam int          n_cmds      = 300;
    localparam int          n_bursts    = 12;
    localparam int          n_qry_cyc   = 400;
    localparam int          step_limit  = 50;
    localparam int          sweep_limit = 1000;
    // Edges from the request cycle to the done cycle
    localparam int          cmd_latency = 2;
    localparam int          qry_latency = 2;

    // Wait conditions
    localparam int W_INIT     = 0;
    localparam int W_READY    = 1;
    localparam int W_DONE     = 2;
    localparam int W_QDONE    = 3;
    localparam int W_UPD_IDLE = 4;
    localparam int W_NOT_FULL = 5;

    logic    clk;
    logic    arst_n;
    logic    ctrl_req;
    db_cmd_t ctrl_cmd;
    key_t    ctrl_key;
    value_t  ctrl_value;
    logic    ctrl_ready;
    logic    ctrl_done;
    logic    ctrl_rsp_valid;
    value_t  ctrl_rsp_value;
    logic    upd_req;
    key_t    upd_key;
    logic    upd_valid;
    value_t  upd_value;
    logic    upd_full;
    logic    upd_busy;
    logic    qry_req;
    key_t    qry_key;
    logic    qry_done;
    logic    qry_valid;
    value_t  qry_value;
    logic    init_done;

    logic [31:0] lcg_state;
    entry_t      model [key_t];
    key_t        pool [pool_size];

    db_core u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // High state bits are the better random ones
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic key_t pick_key();
        logic [31:0] r;
        r = next_rand();
        return pool[r[2:0]];
    endfunction

    function automatic logic cond_met(input int sel);
        case (sel)
            W_INIT:     return init_done;
            W_READY:    return ctrl_ready;
            W_DONE:     return ctrl_done;
            W_QDONE:    return qry_done;
            W_UPD_IDLE: return !upd_busy;
            default:    return !upd_full;
        endcase
    endfunction

    task automatic stop_fail(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic clear_model();
        for (int k = 0; k < db_size; k++) begin
            model[key_t'(k)] = '0;
        end
    endtask

    // Called on a falling edge and returns on the falling edge where the condition holds
    task automatic wait_cond(input int sel, input string what, input int limit,
                             output int cycles);
        cycles = 0;
        while (!cond_met(sel)) begin
            if (sel == W_DONE) begin
                assert (!ctrl_ready) else
                    stop_fail($sformatf("ctrl_ready rose before ctrl_done at %0t ns", $time));
            end
            if (cycles >= limit) begin
                stop_fail($sformatf("Timeout at %0t ns while waiting for %s", $time, what));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic check_entry(input string what, input key_t key, input logic valid,
                               input value_t value, input entry_t exp);
        assert (valid === exp.valid && value === exp.value) else
            stop_fail($sformatf("MISMATCH at %0t ns: %s key %0d returned %b/%h, expected %b/%h",
                                $time, what, key, valid, value, exp.valid, exp.value));
    endtask

    // Response check before the table rules
    task automatic finish_cmd(input db_cmd_t cmd, input key_t key, input value_t value);
        entry_t exp;
        if (cmd == CMD_CLEAR) begin
            exp = '0;
        end else begin
            exp = model[key];
        end
        check_entry(cmd.name(), key, ctrl_rsp_valid, ctrl_rsp_value, exp);
        case (cmd)
            CMD_SET, CMD_REPLACE: model[key] = {1'b1, value};
            CMD_UNSET:            model[key] = '0;
            CMD_CLEAR:            clear_model();
            default:              model[key] = exp;
        endcase
    endtask

    task automatic do_cmd(input db_cmd_t cmd, input key_t key, input value_t value);
        int waited;
        wait_cond(W_READY, "ctrl_ready", (cmd == CMD_CLEAR) ? sweep_limit : step_limit, waited);
        ctrl_req   = 1'b1;
        ctrl_cmd   = cmd;
        ctrl_key   = key;
        ctrl_value = value;
        @(negedge clk);
        ctrl_req = 1'b0;
        wait_cond(W_DONE, "ctrl_done", sweep_limit, waited);
        if (cmd != CMD_CLEAR) begin
            assert (waited + 1 == cmd_latency) else
                stop_fail($sformatf("ctrl_done for %s came %0d cycles after the request",
                                    cmd.name(), waited + 1));
        end
        finish_cmd(cmd, key, value);
    endtask

    task automatic query_check(input key_t key);
        entry_t exp;
        int     waited;
        exp     = model[key];
        qry_req = 1'b1;
        qry_key = key;
        @(negedge clk);
        qry_req = 1'b0;
        wait_cond(W_QDONE, "qry_done", step_limit, waited);
        assert (waited + 1 == qry_latency) else
            stop_fail($sformatf("qry_done for key %0d came %0d cycles after the request",
                                key, waited + 1));
        check_entry("query", key, qry_valid, qry_value, exp);
    endtask

    // Back-to-back posted updates to one key where the last one wins
    task automatic post_burst(input key_t key);
        int          n;
        int          i;
        int          waited;
        logic [31:0] rnd;
        entry_t      upd;
        rnd = next_rand();
        n   = 1 + int'(rnd[1:0]);
        for (i = 0; i < n; i++) begin
            wait_cond(W_NOT_FULL, "upd_full low", step_limit, waited);
            rnd        = next_rand();
            upd        = {rnd[5], next_rand()};
            upd_req    = 1'b1;
            upd_key    = key;
            upd_valid  = upd.valid;
            upd_value  = upd.value;
            model[key] = upd;
            @(negedge clk);
            upd_req = 1'b0;
        end
        wait_cond(W_UPD_IDLE, "upd_busy low", step_limit, waited);
    endtask

    // ====================
    // Query traffic
    // ====================
    task automatic run_query_traffic(input int n_cycles);
        int          cyc;
        int          cmd_cyc;
        int          waited;
        logic        cmd_busy;
        key_t        set_key;
        value_t      set_value;
        key_t        key;
        logic [31:0] rnd;
        int          issue_q[$];
        key_t        qkey_q[$];
        entry_t      expect_q[$];
        cmd_busy  = 1'b0;
        cmd_cyc   = 0;
        set_key   = '0;
        set_value = '0;
        wait_cond(W_READY, "ctrl_ready", step_limit, waited);
        @(negedge clk);
        for (cyc = 0; cyc < n_cycles + 3; cyc++) begin
            if (qry_done) begin
                assert (issue_q.size() > 0 && issue_q[0] == cyc - qry_latency) else
                    stop_fail($sformatf("Unexpected qry_done at %0t ns", $time));
                check_entry("query", qkey_q[0], qry_valid, qry_value, expect_q[0]);
                void'(issue_q.pop_front());
                void'(qkey_q.pop_front());
                void'(expect_q.pop_front());
            end else begin
                assert (issue_q.size() == 0 || issue_q[0] > cyc - qry_latency) else
                    stop_fail($sformatf("qry_done missing at %0t ns", $time));
            end
            // Set is written at the end of its response cycle
            if (ctrl_done) begin
                assert (cmd_busy && cyc == cmd_cyc + cmd_latency) else
                    stop_fail($sformatf("ctrl_done out of place at %0t ns", $time));
                finish_cmd(CMD_SET, set_key, set_value);
                cmd_busy = 1'b0;
            end
            ctrl_req = 1'b0;
            rnd      = next_rand();
            if (cyc < n_cycles && !cmd_busy && ctrl_ready && rnd[1:0] == 2'b00) begin
                set_key    = pick_key();
                set_value  = next_rand();
                ctrl_req   = 1'b1;
                ctrl_cmd   = CMD_SET;
                ctrl_key   = set_key;
                ctrl_value = set_value;
                cmd_busy   = 1'b1;
                cmd_cyc    = cyc;
            end
            qry_req = (cyc < n_cycles);
            if (qry_req) begin
                // Often hit the key being written this cycle
                key     = (ctrl_done && rnd[2]) ? set_key : pick_key();
                qry_key = key;
                issue_q.push_back(cyc);
                qkey_q.push_back(key);
                expect_q.push_back(model[key]);
            end
            @(negedge clk);
        end
        assert (!cmd_busy && issue_q.size() == 0) else
            stop_fail("Query traffic ended with requests still outstanding");
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int          waited;
        int          i;
        logic [31:0] rnd;
        db_cmd_t     cmd;
        key_t        key;
        arst_n     = 1'b0;
        ctrl_req   = 1'b0;
        ctrl_cmd   = CMD_GET;
        ctrl_key   = '0;
        ctrl_value = '0;
        upd_req    = 1'b0;
        upd_key    = '0;
        upd_valid  = 1'b0;
        upd_value  = '0;
        qry_req    = 1'b0;
        qry_key    = '0;
        lcg_state  = seed;
        clear_model();

        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        assert (!ctrl_ready && !ctrl_done && !qry_done && !init_done && !upd_full && !upd_busy)
            else stop_fail("Outputs are not low after reset");

        // Startup sweep leaves an empty table
        wait_cond(W_INIT, "init_done", sweep_limit, waited);
        assert (ctrl_ready) else
            stop_fail($sformatf("ctrl_ready did not rise with init_done at %0t ns", $time));
        for (i = 0; i < pool_size; i++) begin
            pool[i] = key_t'(next_rand());
        end
        for (i = 0; i < 8; i++) begin
            do_cmd(CMD_GET, key_t'(next_rand()), next_rand());
        end

        for (i = 0; i < n_cmds; i++) begin
            rnd = next_rand();
            case (rnd[1:0])
                2'd0:    cmd = CMD_GET;
                2'd1:    cmd = CMD_SET;
                2'd2:    cmd = CMD_UNSET;
                default: cmd = CMD_REPLACE;
            endcase
            do_cmd(cmd, pick_key(), next_rand());
        end

        for (i = 0; i < n_bursts; i++) begin
            key = pick_key();
            post_burst(key);
            query_check(key);
        end

        run_query_traffic(n_qry_cyc);

        // Every pool key reads empty after a clear
        do_cmd(CMD_CLEAR, '0, '0);
        for (i = 0; i < pool_size; i++) begin
            do_cmd(CMD_GET, pool[i], '0);
            query_check(pool[i]);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/db_pkg.sv
hdl/db_store_array.sv
hdl/db_update_fifo.sv
hdl/db_query_pipe.sv
hdl/db_ctrl_fsm.sv
hdl/db_core.sv
bench/tb_db_core.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the db_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
    --top-module tb_db_core -Mdir obj_dir -o sim_db_core \
    -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_db_core > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "STATUS: FAIL" "$log"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
